// File: Bender.yml
package:
  name: frog

export_include_dirs:
  - .

sources:
  - files:
      - frog_pkg.sv
      - move_tick.sv
      - sprite_mover.sv
      - plot_arbiter.sv
      - crash_judge.sv
      - score_display.sv
      - frog_top.sv
  - target: test
    files:
      - tb_frog.sv

// File: build.f
+incdir+.
frog_pkg.sv
move_tick.sv
sprite_mover.sv
plot_arbiter.sv
crash_judge.sv
score_display.sv
frog_top.sv
tb_frog.sv

// File: crash_judge.sv
`timescale 1ns/1ps
`default_nettype none
`include "frog_defs.svh"

module crash_judge
    import frog_pkg::*;
(
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire sprite_pos_t         player,
    input  wire sprite_pos_t         cars [`FROG_CAR_COUNT],
    output logic                     restart,
    output game_event_t              game_event,
    output logic [`FROG_SCORE_W-1:0] score
);

    logic goal_hit;
    logic crash_hit;

    always_comb
    begin
        crash_hit = 1'b0;
        for (int i = 0; i < `FROG_CAR_COUNT; i++)
            crash_hit = crash_hit || (player == cars[i]);
        goal_hit = (player.y == `FROG_GOAL_ROW);
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            restart    <= 1'b0;
            game_event <= '0;
            score      <= '0;
        end
        else if (restart)
        begin
            // player still sits on the hit pixel until the mover reloads its start
            restart    <= 1'b0;
            game_event <= '0;
        end
        else
        begin
            restart          <= goal_hit || crash_hit;
            game_event.goal  <= goal_hit;
            game_event.crash <= crash_hit && !goal_hit;   // goal wins
            if (goal_hit)
                score <= (score == `FROG_SCORE_MAX) ? '0 : score + 1'b1;
            else if (crash_hit)
                score <= '0;
        end
    end

    // a single event per hit, never both kinds and never two cycles running
    a_event_single: assert property (@(posedge clk) disable iff (!reset_n)
        (|game_event) |-> $onehot(game_event) ##1 (game_event == '0));

endmodule

`default_nettype wire

// File: frog_defs.svh
`ifndef FROG_DEFS_SVH
`define FROG_DEFS_SVH

// screen and word widths
`define FROG_COORD_W        7
`define FROG_X_MAX          7'd126      // horizontal wrap column
`define FROG_Y_MAX          7'd119
`define FROG_COLOUR_W       3

`define FROG_PLAYER_COLOUR  3'b010      // green
`define FROG_CAR_COLOUR     3'b100      // red
`define FROG_ERASE_COLOUR   3'b000

// ladder segments, column plus row range
`define FROG_LADDER_A_X     7'd126
`define FROG_LADDER_A_Y_MIN 7'd86
`define FROG_LADDER_A_Y_MAX 7'd117
`define FROG_LADDER_B_X     7'd16
`define FROG_LADDER_B_Y_MIN 7'd56
`define FROG_LADDER_B_Y_MAX 7'd86
`define FROG_LADDER_C_X     7'd126
`define FROG_LADDER_C_Y_MIN 7'd3
`define FROG_LADDER_C_Y_MAX 7'd56

`define FROG_GOAL_ROW       7'd3
`define FROG_PLAYER_START_X 7'd5
`define FROG_PLAYER_START_Y 7'd117

`define FROG_CAR_COUNT      6
`define FROG_TICK_CYCLES    2500000     // clock cycles per move
`define FROG_SCORE_W        7
`define FROG_SCORE_MAX      7'd99

`endif

// File: frog_pkg.sv
`default_nettype none
`include "frog_defs.svh"

package frog_pkg;

    typedef logic [`FROG_COORD_W-1:0]  coord_t;
    typedef logic [`FROG_COLOUR_W-1:0] colour_t;

    // one pixel write towards the plotter
    typedef struct packed {
        coord_t  x;
        coord_t  y;
        colour_t colour;
        logic    write;
    } plot_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } sprite_pos_t;

    // movement levels, listed in priority order
    typedef struct packed {
        logic right;
        logic left;
        logic down;
        logic up;
    } keys_t;

    typedef struct packed {
        logic goal;
        logic crash;
    } game_event_t;

endpackage

`default_nettype wire

// File: frog_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "frog_defs.svh"

module frog_top
    import frog_pkg::*;
#(
    parameter int tick_cycles = `FROG_TICK_CYCLES
)
(
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire keys_t               keys,
    output plot_t                    plot,
    output game_event_t              game_event,
    output logic [`FROG_SCORE_W-1:0] score,
    output logic [6:0]               hex_tens,
    output logic [6:0]               hex_ones
);

    // one lane per car, the lane row is the start row
    localparam sprite_pos_t car_start [`FROG_CAR_COUNT] = '{
        '{x: 7'd47, y: 7'd42},
        '{x: 7'd48, y: 7'd36},
        '{x: 7'd36, y: 7'd70},
        '{x: 7'd83, y: 7'd82},
        '{x: 7'd81, y: 7'd97},
        '{x: 7'd56, y: 7'd107}
    };
    localparam logic [`FROG_CAR_COUNT-1:0] car_goes_right = 6'b101101;
    localparam keys_t go_right = 4'b1000;
    localparam keys_t go_left  = 4'b0100;

    logic [`FROG_CAR_COUNT:0] ticks;
    logic                     restart;
    sprite_pos_t              player_pos;
    sprite_pos_t              car_pos [`FROG_CAR_COUNT];
    plot_t                    sprite_plots [`FROG_CAR_COUNT+1];

    move_tick #(.tick_cycles(tick_cycles)) move_tick_inst (.clk, .reset_n, .ticks);

    sprite_mover #(
        .start_pos ('{x: `FROG_PLAYER_START_X, y: `FROG_PLAYER_START_Y}),
        .colour    (`FROG_PLAYER_COLOUR),
        .is_player (1'b1)
    ) player_inst (
        .clk, .reset_n, .tick(ticks[0]), .keys, .restart,
        .plot(sprite_plots[0]), .pos(player_pos)
    );

    for (genvar i = 0; i < `FROG_CAR_COUNT; i++)
    begin : g_car
        sprite_mover #(
            .start_pos (car_start[i]),
            .colour    (`FROG_CAR_COLOUR),
            .is_player (1'b0)
        ) car_inst (
            .clk, .reset_n, .tick(ticks[i+1]),
            .keys(car_goes_right[i] ? go_right : go_left), .restart(1'b0),
            .plot(sprite_plots[i+1]), .pos(car_pos[i])
        );
    end

    plot_arbiter plot_arbiter_inst (.clk, .reset_n, .sprite_plots, .plot);

    crash_judge crash_judge_inst (
        .clk, .reset_n, .player(player_pos), .cars(car_pos), .restart, .game_event, .score
    );

    score_display score_display_inst (.score, .hex_tens, .hex_ones);

endmodule

`default_nettype wire

// File: move_tick.sv
`timescale 1ns/1ps
`default_nettype none
`include "frog_defs.svh"

module move_tick
#(
    parameter int tick_cycles = `FROG_TICK_CYCLES
)
(
    input  wire                      clk,
    input  wire                      reset_n,
    output logic [`FROG_CAR_COUNT:0] ticks     // bit 0 is the player
);

    localparam int cnt_w = $clog2(tick_cycles);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            count <= '0;
        else if (count == cnt_w'(tick_cycles - 1))
            count <= '0;
        else
            count <= count + 1'b1;
    end

    // sprite i moves two cycles after sprite i-1, so erase/draw pairs never overlap
    always_comb
    begin
        for (int i = 0; i <= `FROG_CAR_COUNT; i++)
            ticks[i] = (count == cnt_w'(2 * i));
    end

    a_ticks_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(ticks));

endmodule

`default_nettype wire

// File: plot_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "frog_defs.svh"

module plot_arbiter
    import frog_pkg::*;
(
    input  wire        clk,
    input  wire        reset_n,
    input  wire plot_t sprite_plots [`FROG_CAR_COUNT+1],   // index 0 is the player
    output plot_t      plot
);

    plot_t winner;
    logic  any_write;

    // scan from the lowest priority up so the lowest index is left standing
    always_comb
    begin
        winner    = sprite_plots[0];
        any_write = 1'b0;
        for (int i = `FROG_CAR_COUNT; i >= 0; i--)
        begin
            if (sprite_plots[i].write)
            begin
                winner    = sprite_plots[i];
                any_write = 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            plot.write <= 1'b0;
        else if (any_write)
            plot <= winner;
        else
            plot.write <= 1'b0;    // last x, y and colour stay put
    end

endmodule

`default_nettype wire

// File: score_display.sv
`timescale 1ns/1ps
`default_nettype none
`include "frog_defs.svh"

module score_display
(
    input  wire [`FROG_SCORE_W-1:0] score,
    output logic [6:0]              hex_tens,    // active low segments
    output logic [6:0]              hex_ones
);

    logic [3:0] tens;
    logic [3:0] ones;

    function automatic logic [6:0] seg7(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0011000;
            default: return 7'b1111111;   // blank
        endcase
    endfunction

    assign tens     = 4'(score / 10);
    assign ones     = 4'(score % 10);
    assign hex_tens = seg7(tens);
    assign hex_ones = seg7(ones);

endmodule

`default_nettype wire

// File: sprite_mover.sv
`timescale 1ns/1ps
`default_nettype none
`include "frog_defs.svh"

module sprite_mover
    import frog_pkg::*;
#(
    parameter sprite_pos_t start_pos = '{x: '0, y: '0},
    parameter colour_t     colour    = `FROG_CAR_COLOUR,
    parameter bit          is_player = 1'b0
)
(
    input  wire              clk,
    input  wire              reset_n,
    input  wire              tick,
    input  wire keys_t       keys,
    input  wire              restart,
    output plot_t            plot,
    output sprite_pos_t      pos
);

    typedef enum logic [1:0] {st_idle, st_erase, st_draw} state_t;
    typedef enum logic [1:0] {dir_right, dir_left, dir_down, dir_up} dir_t;

    state_t      state;
    dir_t        dir;        // direction latched at the tick
    dir_t        key_dir;
    sprite_pos_t next_pos;
    logic        move_req;
    logic        do_restart;

    // true when (x, y) lies on one of the three ladder segments
    function automatic logic on_ladder(input coord_t x, input coord_t y);
        logic in_a;
        logic in_b;
        logic in_c;
        in_a = (x == `FROG_LADDER_A_X)
            && (y >= `FROG_LADDER_A_Y_MIN) && (y <= `FROG_LADDER_A_Y_MAX);
        in_b = (x == `FROG_LADDER_B_X)
            && (y >= `FROG_LADDER_B_Y_MIN) && (y <= `FROG_LADDER_B_Y_MAX);
        in_c = (x == `FROG_LADDER_C_X)
            && (y >= `FROG_LADDER_C_Y_MIN) && (y <= `FROG_LADDER_C_Y_MAX);
        return in_a || in_b || in_c;
    endfunction

    assign move_req   = |keys;
    assign do_restart = is_player && restart;   // cars keep driving through a crash

    always_comb
    begin
        if (keys.right)
            key_dir = dir_right;
        else if (keys.left)
            key_dir = dir_left;
        else if (keys.down)
            key_dir = dir_down;
        else
            key_dir = dir_up;
    end

    always_comb
    begin
        next_pos = pos;
        case (dir)
            dir_right: next_pos.x = (pos.x == `FROG_X_MAX) ? '0 : pos.x + 1'b1;
            dir_left:  next_pos.x = (pos.x == '0) ? `FROG_X_MAX : pos.x - 1'b1;
            dir_down:
            begin
                if (on_ladder(pos.x, pos.y + 1'b1))
                    next_pos.y = pos.y + 1'b1;
            end
            default:
            begin
                if (on_ladder(pos.x, pos.y - 1'b1))   // row 0 wraps to 127, off every ladder
                    next_pos.y = pos.y - 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n || do_restart)
        begin
            state      <= st_idle;
            pos        <= start_pos;
            plot.write <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (tick && move_req)
                    begin
                        state <= st_erase;
                        dir   <= key_dir;
                        plot  <= '{x: pos.x, y: pos.y, colour: `FROG_ERASE_COLOUR, write: 1'b1};
                    end
                end
                st_erase:
                begin
                    // a blocked vertical step redraws in place
                    state <= st_draw;
                    pos   <= next_pos;
                    plot  <= '{x: next_pos.x, y: next_pos.y, colour: colour, write: 1'b1};
                end
                default:
                begin
                    state      <= st_idle;
                    plot.write <= 1'b0;
                end
            endcase
        end
    end

    a_idle_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        (state == st_idle) |-> !plot.write);

endmodule

`default_nettype wire

// File: tb_frog.sv
`timescale 1ns/1ps
`default_nettype none
`include "frog_defs.svh"

module tb_frog
    import frog_pkg::*;
();

    localparam int max_cycles = 40000;   // walk, climbs and car waits fit well inside
    localparam sprite_pos_t start_pos = '{x: `FROG_PLAYER_START_X, y: `FROG_PLAYER_START_Y};
    localparam keys_t right_key = '{right: 1'b1, left: 1'b0, down: 1'b0, up: 1'b0};
    localparam keys_t left_key  = '{right: 1'b0, left: 1'b1, down: 1'b0, up: 1'b0};
    localparam keys_t up_key    = '{right: 1'b0, left: 1'b0, down: 1'b0, up: 1'b1};
    // active low digit patterns 0 to 9
    localparam logic [6:0] seg_table [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                              7'h12, 7'h02, 7'h78, 7'h00, 7'h18};

    logic                     clk;
    logic                     reset_n;
    keys_t                    keys;
    plot_t                    plot;
    game_event_t              game_event;
    logic [`FROG_SCORE_W-1:0] score;
    logic [6:0]               hex_tens;
    logic [6:0]               hex_ones;

    sprite_pos_t player_at;          // last player draw seen on the plot stream
    sprite_pos_t next_expected;
    coord_t      car_x [128];        // last car draw per lane row
    bit          car_seen [128];
    int          player_draws = 0;
    int          goals = 0;
    int          crashes = 0;
    int          exp_score = 0;
    int          cycle_count = 0;
    bit          reset_checked = 1'b0;
    int unsigned seed_init;

    frog_top #(.tick_cycles(16)) frog_top_inst (
        .clk, .reset_n, .keys, .plot, .game_event, .score, .hex_tens, .hex_ones
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // both rows on the same ladder segment
    function automatic bit ladder_allows(input coord_t x, input coord_t ya, input coord_t yb);
        coord_t col [3];
        coord_t lo [3];
        coord_t hi [3];
        bit     ok;
        col = '{`FROG_LADDER_A_X, `FROG_LADDER_B_X, `FROG_LADDER_C_X};
        lo  = '{`FROG_LADDER_A_Y_MIN, `FROG_LADDER_B_Y_MIN, `FROG_LADDER_C_Y_MIN};
        hi  = '{`FROG_LADDER_A_Y_MAX, `FROG_LADDER_B_Y_MAX, `FROG_LADDER_C_Y_MAX};
        ok  = 1'b0;
        for (int i = 0; i < 3; i++)
            if (x == col[i] && ya >= lo[i] && ya <= hi[i] && yb >= lo[i] && yb <= hi[i])
                ok = 1'b1;
        return ok;
    endfunction

    function automatic sprite_pos_t expected_move(input sprite_pos_t from, input keys_t k);
        sprite_pos_t to;
        to = from;
        if (k.right)
            to.x = (from.x == `FROG_X_MAX) ? 7'd0 : from.x + 7'd1;
        else if (k.left)
            to.x = (from.x == 7'd0) ? `FROG_X_MAX : from.x - 7'd1;
        else if (k.down && ladder_allows(from.x, from.y, from.y + 7'd1))
            to.y = from.y + 7'd1;
        else if (k.up && ladder_allows(from.x, from.y, from.y - 7'd1))
            to.y = from.y - 7'd1;
        return to;
    endfunction

    // column distance on a screen that wraps after 127 columns
    function automatic int lane_gap(input coord_t a, input coord_t b);
        int d;
        d = (a > b) ? int'(a) - int'(b) : int'(b) - int'(a);
        return (d > 63) ? 127 - d : d;
    endfunction

    task automatic press_key(input keys_t k);
        int draws_before;
        draws_before = player_draws;
        keys = k;
        while (player_draws == draws_before)
            @(negedge clk);
        keys = '0;
        repeat ($urandom_range(3, 0)) @(negedge clk);
    endtask

    task automatic wait_lane_clear(input coord_t row);
        while (car_seen[row] && lane_gap(car_x[row], player_at.x) <= 8)
            @(negedge clk);
    endtask

    task automatic walk_to_column(input coord_t col, input keys_t k);
        while (player_at.x != col)
            press_key(k);
    endtask

    task automatic climb_to_row(input coord_t row);
        while (player_at.y != row)
        begin
            wait_lane_clear(player_at.y - 7'd1);
            press_key(up_key);
        end
    endtask

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= max_cycles)
            fail_run($sformatf("timeout: run did not finish within %0d cycles", max_cycles));
    end

    // plot stream tracking and all checks on values settled before the edge
    always @(posedge clk)
    begin
        if (reset_n)
        begin
            if (!reset_checked)
            begin
                assert (!plot.write) else fail_run("ERROR: plot.write is 0x1, expected 0x0");
                assert (game_event == '0)
                    else fail_run($sformatf("ERROR: game_event is 0x%h, expected 0x0", game_event));
                reset_checked = 1'b1;
            end
            if (plot.write)
            begin
                assert (plot.x <= `FROG_X_MAX && plot.y <= `FROG_Y_MAX)
                    else fail_run($sformatf("ERROR: plot x/y is 0x%h/0x%h, off screen",
                                            plot.x, plot.y));
                if (plot.colour == `FROG_PLAYER_COLOUR)
                begin
                    if (plot.y != player_at.y)
                    begin
                        assert (ladder_allows(plot.x, player_at.y, plot.y))
                            else fail_run("player changed row away from a ladder segment");
                    end
                    next_expected = expected_move(player_at, keys);
                    assert (plot.x == next_expected.x)
                        else fail_run($sformatf("ERROR: player plot.x is 0x%h, expected 0x%h",
                                                plot.x, next_expected.x));
                    assert (plot.y == next_expected.y)
                        else fail_run($sformatf("ERROR: player plot.y is 0x%h, expected 0x%h",
                                                plot.y, next_expected.y));
                    player_at = '{x: plot.x, y: plot.y};
                    player_draws++;
                end
                else if (plot.colour == `FROG_CAR_COLOUR)
                begin
                    car_x[plot.y]    = plot.x;
                    car_seen[plot.y] = 1'b1;
                end
            end
            if (game_event.goal)
            begin
                assert (player_at.y == `FROG_GOAL_ROW)
                    else fail_run("goal pulse without a player draw on the goal row");
                exp_score = (exp_score == `FROG_SCORE_MAX) ? 0 : exp_score + 1;
                goals++;
                player_at = start_pos;
            end
            if (game_event.crash)
            begin
                assert (car_seen[player_at.y] && car_x[player_at.y] == player_at.x)
                    else fail_run("crash pulse while no car sits on the player");
                exp_score = 0;
                crashes++;
                player_at = start_pos;
            end
            assert (score == exp_score)
                else fail_run($sformatf("ERROR: score is 0x%h, expected 0x%h", score, exp_score));
            assert (hex_tens == seg_table[exp_score / 10])
                else fail_run($sformatf("ERROR: hex_tens is 0x%h, expected 0x%h",
                                        hex_tens, seg_table[exp_score / 10]));
            assert (hex_ones == seg_table[exp_score % 10])
                else fail_run($sformatf("ERROR: hex_ones is 0x%h, expected 0x%h",
                                        hex_ones, seg_table[exp_score % 10]));
        end
    end

    initial
    begin
        seed_init = $urandom(89);
        player_at = start_pos;
        keys      = '0;
        reset_n   = 1'b0;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        repeat (2) @(negedge clk);

        walk_to_column(`FROG_LADDER_A_X, right_key);
        climb_to_row(`FROG_LADDER_A_Y_MIN);
        walk_to_column(`FROG_LADDER_B_X, left_key);
        climb_to_row(`FROG_LADDER_B_Y_MIN);
        walk_to_column(`FROG_LADDER_C_X, right_key);
        climb_to_row(`FROG_GOAL_ROW + 7'd1);
        press_key(up_key);                       // last step onto the goal row
        assert (goals == 1) else fail_run("no goal pulse after reaching the goal row");

        // park in the lane of the right-going car at row 107
        walk_to_column(`FROG_LADDER_A_X, right_key);
        climb_to_row(7'd107);
        while (crashes == 0)
            @(negedge clk);
        repeat (4) @(negedge clk);

        if (goals == 1 && crashes == 1)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
            fail_run("event count differs from one goal and one crash");
    end

endmodule

`default_nettype wire
